//--- include/ex_params.svh
`ifndef EX_PARAMS_SVH
`define EX_PARAMS_SVH

// datapath and pc width
`define EX_XLEN 32

// architectural register index width
`define EX_REG_W 5

// csr number width, taken from the low immediate bits
`define EX_CSR_W 14

// divider busy cycles, one quotient bit each
`define EX_DIV_CYCLES 32

// nop encoding with all fields zero
`define EX_INST_NOP 32'h0000_0000

// instruction field positions
`define EX_OPC_MSB 31
`define EX_OPC_LSB 26
`define EX_IMM_W 16

`endif

//--- hdl/ex_uop_pkg.sv
`default_nettype none

package ex_uop_pkg;

    // opcode in inst[31:26]
    // codes not listed here decode as illegal
    typedef enum logic [5:0] {
        OP_NOP     = 6'h00,
        OP_ADD     = 6'h01,
        OP_SUB     = 6'h02,
        OP_AND     = 6'h03,
        OP_OR      = 6'h04,
        OP_XOR     = 6'h05,
        OP_SLL     = 6'h06,
        OP_SRL     = 6'h07,
        OP_SLTU    = 6'h08,
        // rd = rj + sext(imm16)
        OP_ADDI    = 6'h09,
        // lane 0 only from here on
        OP_DIVU    = 6'h0a,
        OP_MODU    = 6'h0b,
        OP_CSRRD   = 6'h0c,
        OP_SYSCALL = 6'h0d
    } op_e;

    // iterative divider control
    typedef enum logic [1:0] {
        DIV_IDLE = 2'b00,
        // one quotient bit per cycle
        DIV_BUSY = 2'b01,
        // result held until the pair leaves ex1
        DIV_DONE = 2'b10
    } div_state_e;

endpackage

`default_nettype wire

//--- hdl/ex_excp_pkg.sv
`default_nettype none

package ex_excp_pkg;

    // exception codes carried into ex2
    typedef enum logic [6:0] {
        // no exception
        EXC_NONE = 7'h00,
        // system call
        EXC_SYS  = 7'h0b,
        // illegal instruction
        EXC_INE  = 7'h0d
    } excp_e;

endpackage

`default_nettype wire

//--- hdl/uop_decode.sv
`timescale 1ns/10ps
`default_nettype none

`include "ex_params.svh"

module uop_decode import ex_uop_pkg::*; (
    input  wire logic [`EX_XLEN-1:0]  inst,
    // tied high on the second lane
    input  wire logic                 lane1,
    output op_e                       op,
    output logic      [`EX_REG_W-1:0] rd,
    output logic      [`EX_REG_W-1:0] rj,
    output logic      [`EX_REG_W-1:0] rk,
    output logic      [`EX_XLEN-1:0]  imm,
    output logic                      illegal,
    output logic                      syscall
);

    logic [`EX_OPC_MSB-`EX_OPC_LSB:0] raw_op;
    logic                             known;
    logic                             lane0_only;

    // fixed field positions
    assign raw_op = inst[`EX_OPC_MSB:`EX_OPC_LSB];
    assign rd     = inst[25:21];
    assign rj     = inst[20:16];
    assign rk     = inst[15:11];

    // imm16 sign-extended, csrrd uses its low bits as csr number
    assign imm = {{(`EX_XLEN-`EX_IMM_W){inst[`EX_IMM_W-1]}}, inst[`EX_IMM_W-1:0]};

    always_comb begin
        known      = 1'b1;
        lane0_only = 1'b0;
        case (raw_op)
            OP_NOP, OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR,
            OP_SLL, OP_SRL, OP_SLTU, OP_ADDI: begin
                lane0_only = 1'b0;
            end
            // divider, csr port and trap only exist on lane 0
            OP_DIVU, OP_MODU, OP_CSRRD, OP_SYSCALL: begin
                lane0_only = 1'b1;
            end
            default: begin
                known = 1'b0;
            end
        endcase
    end

    assign illegal = ~known | (lane0_only & lane1);

    // illegal words travel on as nop, the flag carries the fault
    assign op = illegal ? OP_NOP : op_e'(raw_op);

    // only a legal lane-0 syscall raises this
    assign syscall = ~illegal & (raw_op == OP_SYSCALL);

endmodule

`default_nettype wire

//--- hdl/alu_unit.sv
`timescale 1ns/10ps
`default_nettype none

`include "ex_params.svh"

module alu_unit import ex_uop_pkg::*; (
    input  op_e                     op,
    // rj value
    input  wire logic [`EX_XLEN-1:0] a,
    // rk value
    input  wire logic [`EX_XLEN-1:0] b,
    input  wire logic [`EX_XLEN-1:0] imm,
    output logic      [`EX_XLEN-1:0] result
);

    localparam int SHAMT_W = $clog2(`EX_XLEN);

    logic [SHAMT_W-1:0] shamt;

    // shift amount from low bits of rk
    assign shamt = b[SHAMT_W-1:0];

    always_comb begin
        case (op)
            OP_ADD: begin
                result = a + b;
            end
            OP_SUB: begin
                result = a - b;
            end
            OP_AND: result = a & b;
            OP_OR:  result = a | b;
            OP_XOR: result = a ^ b;
            OP_SLL: begin
                result = a << shamt;
            end
            // logical, zero fill
            OP_SRL: begin
                result = a >> shamt;
            end
            OP_SLTU: begin
                result = {{(`EX_XLEN-1){1'b0}}, (a < b)};
            end
            OP_ADDI: begin
                result = a + imm;
            end
            // nop, divide, csr and trap have no alu result
            default: begin
                result = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- hdl/div_unit.sv
`timescale 1ns/10ps
`default_nettype none

`include "ex_params.svh"

module div_unit import ex_uop_pkg::*; (
    input  wire logic                clk,
    input  wire logic                rst_n,
    // lane-0 divide waiting in ex1
    input  wire logic                start,
    input  wire logic [`EX_XLEN-1:0] dividend,
    input  wire logic [`EX_XLEN-1:0] divisor,
    // pair leaves ex1 this cycle
    input  wire logic                ex1_fire,
    output logic      [`EX_XLEN-1:0] quotient,
    output logic      [`EX_XLEN-1:0] remainder,
    output logic                     div_done
);

    localparam int CNT_W = $clog2(`EX_DIV_CYCLES);
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(`EX_DIV_CYCLES - 1);

    div_state_e         state;
    logic [CNT_W-1:0]   count;
    logic [`EX_XLEN-1:0] rem_q;
    logic [`EX_XLEN-1:0] quo_q;
    logic [`EX_XLEN-1:0] dvsr_q;
    logic [`EX_XLEN:0]   shifted;
    logic [`EX_XLEN:0]   diff;
    logic                fits;

    // partial remainder with next dividend bit shifted in
    assign shifted = {rem_q, quo_q[`EX_XLEN-1]};
    assign diff    = shifted - {1'b0, dvsr_q};
    assign fits    = (shifted >= {1'b0, dvsr_q});

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= DIV_IDLE;
            count <= '0;
        end else begin
            case (state)
                DIV_IDLE: begin
                    count <= '0;
                    if (start) begin
                        state <= DIV_BUSY;
                    end
                end
                DIV_BUSY: begin
                    count <= count + 1'b1;
                    if (count == CNT_LAST) begin
                        state <= DIV_DONE;
                    end
                end
                // hold until the register takes the result
                DIV_DONE: begin
                    if (ex1_fire) begin
                        state <= DIV_IDLE;
                    end
                end
                default: state <= DIV_IDLE;
            endcase
        end
    end

    // datapath, dividend bits leave quo_q as quotient bits enter
    // divisor 0 always fits, so q ends all ones and rem ends at dividend
    always_ff @(posedge clk) begin
        if (state == DIV_IDLE && start) begin
            rem_q  <= '0;
            quo_q  <= dividend;
            dvsr_q <= divisor;
        end else if (state == DIV_BUSY) begin
            rem_q <= fits ? diff[`EX_XLEN-1:0] : shifted[`EX_XLEN-1:0];
            quo_q <= {quo_q[`EX_XLEN-2:0], fits};
        end
    end

    assign quotient  = quo_q;
    assign remainder = rem_q;
    assign div_done  = (state == DIV_DONE);

endmodule

`default_nettype wire

//--- hdl/ex1_ex2_reg.sv
`timescale 1ns/10ps
`default_nettype none

`include "ex_params.svh"

module ex1_ex2_reg import ex_uop_pkg::*, ex_excp_pkg::*; (
    input  wire logic                 clk,
    input  wire logic                 rst_n,
    input  wire logic                 flush,
    input  wire logic                 ex1_readygo,
    input  wire logic                 ex2_allowin,
    input  wire logic                 div_done,
    input  wire logic [`EX_XLEN-1:0]  pc0,
    input  wire logic [`EX_XLEN-1:0]  pc1,
    input  wire logic [`EX_XLEN-1:0]  inst0,
    input  wire logic [`EX_XLEN-1:0]  inst1,
    input  op_e                       op0,
    input  op_e                       op1,
    input  wire logic [`EX_REG_W-1:0] rd0,
    input  wire logic [`EX_REG_W-1:0] rd1,
    input  wire logic                 illegal0,
    input  wire logic                 illegal1,
    input  wire logic                 syscall0,
    input  wire logic [`EX_XLEN-1:0]  alu_result0,
    input  wire logic [`EX_XLEN-1:0]  alu_result1,
    input  wire logic [`EX_XLEN-1:0]  quotient,
    input  wire logic [`EX_XLEN-1:0]  remainder,
    input  wire logic [`EX_XLEN-1:0]  csr_rdata,
    output logic                      ex1_allowin,
    output logic                      ex1_fire,
    output logic                      ex2_valid,
    output logic      [`EX_XLEN-1:0]  ex2_pc0,
    output logic      [`EX_XLEN-1:0]  ex2_pc1,
    output logic      [`EX_XLEN-1:0]  ex2_inst0,
    output logic      [`EX_XLEN-1:0]  ex2_inst1,
    output logic      [`EX_REG_W-1:0] ex2_rd0,
    output logic      [`EX_REG_W-1:0] ex2_rd1,
    output logic      [`EX_XLEN-1:0]  ex2_data0,
    output logic      [`EX_XLEN-1:0]  ex2_data1,
    output logic                      ex2_we0,
    output logic                      ex2_we1,
    output logic                      ex2_csr_ren,
    output logic                      ex2_excp_flag,
    output excp_e                     ex2_exception,
    output logic      [`EX_XLEN-1:0]  ex2_badv
);

    logic                is_div0;
    logic                div_stall;
    logic                bubble;
    logic                exc0;
    logic                exc1;
    logic [`EX_XLEN-1:0] data0_nxt;
    logic                we0_nxt;
    logic                we1_nxt;
    excp_e               code_nxt;
    logic [`EX_XLEN-1:0] badv_nxt;

    // divide in lane 0 blocks entry until the divider finishes
    assign is_div0     = (op0 == OP_DIVU) || (op0 == OP_MODU);
    assign div_stall   = ex1_readygo & is_div0 & ~div_done;
    assign ex1_allowin = ex2_allowin & ~div_stall;
    assign ex1_fire    = ex1_readygo & ex1_allowin;

    // ex1 empty while ex2 drains, or a flush
    assign bubble = flush | (~ex1_readygo & ex2_allowin);

    // lane-1 syscall already decodes as illegal
    assign exc0 = illegal0 | syscall0;
    assign exc1 = illegal1;

    // lane-0 result source
    always_comb begin
        case (op0)
            OP_MODU:  data0_nxt = remainder;
            OP_DIVU:  data0_nxt = quotient;
            OP_CSRRD: data0_nxt = csr_rdata;
            default:  data0_nxt = alu_result0;
        endcase
    end

    // no write to r0, on a fault, or for nop and trap
    assign we0_nxt = (rd0 != '0) & ~exc0 & (op0 != OP_NOP) & (op0 != OP_SYSCALL);
    // an older fault in lane 0 squashes lane 1 too
    assign we1_nxt = (rd1 != '0) & ~exc1 & ~exc0 & (op1 != OP_NOP) & (op1 != OP_SYSCALL);

    // lane 0 wins when both lanes fault
    always_comb begin
        if (exc0) begin
            code_nxt = illegal0 ? EXC_INE : EXC_SYS;
            badv_nxt = pc0;
        end else if (exc1) begin
            code_nxt = EXC_INE;
            badv_nxt = pc1;
        end else begin
            code_nxt = EXC_NONE;
            badv_nxt = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n || bubble) begin
            ex2_valid     <= 1'b0;
            ex2_pc0       <= '0;
            ex2_pc1       <= '0;
            ex2_inst0     <= `EX_INST_NOP;
            ex2_inst1     <= `EX_INST_NOP;
            ex2_rd0       <= '0;
            ex2_rd1       <= '0;
            ex2_data0     <= '0;
            ex2_data1     <= '0;
            ex2_we0       <= 1'b0;
            ex2_we1       <= 1'b0;
            ex2_csr_ren   <= 1'b0;
            ex2_excp_flag <= 1'b0;
            ex2_exception <= EXC_NONE;
            ex2_badv      <= '0;
        end else if (ex1_fire) begin
            ex2_valid     <= 1'b1;
            ex2_pc0       <= pc0;
            ex2_pc1       <= pc1;
            ex2_inst0     <= inst0;
            ex2_inst1     <= inst1;
            ex2_rd0       <= rd0;
            ex2_rd1       <= rd1;
            ex2_data0     <= data0_nxt;
            // lane 1 has only the alu
            ex2_data1     <= alu_result1;
            ex2_we0       <= we0_nxt;
            ex2_we1       <= we1_nxt;
            ex2_csr_ren   <= (op0 == OP_CSRRD);
            ex2_excp_flag <= exc0 | exc1;
            ex2_exception <= code_nxt;
            ex2_badv      <= badv_nxt;
        end
        // otherwise ex2 is stalled, hold everything
    end

endmodule

`default_nettype wire

//--- hdl/ex_top.sv
`timescale 1ns/10ps
`default_nettype none

`include "ex_params.svh"

module ex_top import ex_uop_pkg::*, ex_excp_pkg::*; (
    input  wire logic                 clk,
    input  wire logic                 rst_n,
    input  wire logic [`EX_XLEN-1:0]  pc0,
    input  wire logic [`EX_XLEN-1:0]  pc1,
    input  wire logic [`EX_XLEN-1:0]  inst0,
    input  wire logic [`EX_XLEN-1:0]  inst1,
    // rj and rk values per lane
    input  wire logic [`EX_XLEN-1:0]  src_a0,
    input  wire logic [`EX_XLEN-1:0]  src_b0,
    input  wire logic [`EX_XLEN-1:0]  src_a1,
    input  wire logic [`EX_XLEN-1:0]  src_b1,
    input  wire logic [`EX_XLEN-1:0]  csr_rdata,
    input  wire logic                 ex1_readygo,
    input  wire logic                 ex2_allowin,
    input  wire logic                 flush,
    output logic                      ex1_allowin,
    output logic      [`EX_CSR_W-1:0] csr_addr,
    output logic                      ex2_valid,
    output logic      [`EX_XLEN-1:0]  ex2_pc0,
    output logic      [`EX_XLEN-1:0]  ex2_pc1,
    output logic      [`EX_XLEN-1:0]  ex2_inst0,
    output logic      [`EX_XLEN-1:0]  ex2_inst1,
    output logic      [`EX_REG_W-1:0] ex2_rd0,
    output logic      [`EX_REG_W-1:0] ex2_rd1,
    output logic      [`EX_XLEN-1:0]  ex2_data0,
    output logic      [`EX_XLEN-1:0]  ex2_data1,
    output logic                      ex2_we0,
    output logic                      ex2_we1,
    output logic                      ex2_csr_ren,
    output logic                      ex2_excp_flag,
    output excp_e                     ex2_exception,
    output logic      [`EX_XLEN-1:0]  ex2_badv
);

    op_e                  dec0_op;
    op_e                  dec1_op;
    logic [`EX_REG_W-1:0] dec0_rd;
    logic [`EX_REG_W-1:0] dec1_rd;
    logic [`EX_XLEN-1:0]  dec0_imm;
    logic [`EX_XLEN-1:0]  dec1_imm;
    logic                 dec0_illegal;
    logic                 dec1_illegal;
    logic                 dec0_syscall;
    logic [`EX_XLEN-1:0]  alu_res0;
    logic [`EX_XLEN-1:0]  alu_res1;
    logic [`EX_XLEN-1:0]  quotient;
    logic [`EX_XLEN-1:0]  remainder;
    logic                 div_done;
    logic                 div_start;
    logic                 ex1_fire;

    // csr number straight from lane-0 immediate
    assign csr_addr = dec0_imm[`EX_CSR_W-1:0];

    // kick the divider while a lane-0 divide sits in ex1
    assign div_start = ex1_readygo & ((dec0_op == OP_DIVU) || (dec0_op == OP_MODU));

    // register fields rj/rk unused, operand values arrive resolved
    uop_decode dec0 (
        .inst(inst0), .lane1(1'b0), .op(dec0_op), .rd(dec0_rd), .rj(), .rk(),
        .imm(dec0_imm), .illegal(dec0_illegal), .syscall(dec0_syscall)
    );

    // lane 1 has no trap path, syscall there shows up as illegal
    uop_decode dec1 (
        .inst(inst1), .lane1(1'b1), .op(dec1_op), .rd(dec1_rd), .rj(), .rk(),
        .imm(dec1_imm), .illegal(dec1_illegal), .syscall()
    );

    alu_unit alu0 (.op(dec0_op), .a(src_a0), .b(src_b0), .imm(dec0_imm), .result(alu_res0));
    alu_unit alu1 (.op(dec1_op), .a(src_a1), .b(src_b1), .imm(dec1_imm), .result(alu_res1));

    div_unit div0 (
        .clk(clk), .rst_n(rst_n), .start(div_start), .dividend(src_a0), .divisor(src_b0),
        .ex1_fire(ex1_fire), .quotient(quotient), .remainder(remainder), .div_done(div_done)
    );

    ex1_ex2_reg pipe0 (
        .clk(clk), .rst_n(rst_n), .flush(flush), .ex1_readygo(ex1_readygo),
        .ex2_allowin(ex2_allowin), .div_done(div_done),
        .pc0(pc0), .pc1(pc1), .inst0(inst0), .inst1(inst1),
        .op0(dec0_op), .op1(dec1_op), .rd0(dec0_rd), .rd1(dec1_rd),
        .illegal0(dec0_illegal), .illegal1(dec1_illegal), .syscall0(dec0_syscall),
        .alu_result0(alu_res0), .alu_result1(alu_res1),
        .quotient(quotient), .remainder(remainder), .csr_rdata(csr_rdata),
        .ex1_allowin(ex1_allowin), .ex1_fire(ex1_fire),
        .ex2_valid(ex2_valid), .ex2_pc0(ex2_pc0), .ex2_pc1(ex2_pc1),
        .ex2_inst0(ex2_inst0), .ex2_inst1(ex2_inst1),
        .ex2_rd0(ex2_rd0), .ex2_rd1(ex2_rd1),
        .ex2_data0(ex2_data0), .ex2_data1(ex2_data1),
        .ex2_we0(ex2_we0), .ex2_we1(ex2_we1), .ex2_csr_ren(ex2_csr_ren),
        .ex2_excp_flag(ex2_excp_flag), .ex2_exception(ex2_exception), .ex2_badv(ex2_badv)
    );

endmodule

`default_nettype wire

//--- dv/ex_tb.sv
`timescale 1ns/10ps
`default_nettype none

`include "ex_params.svh"

module ex_tb import ex_uop_pkg::*, ex_excp_pkg::*; ();

    localparam int NUM_PAIRS      = 300;
    localparam int TIMEOUT_CYCLES = NUM_PAIRS * (`EX_DIV_CYCLES + 8);

    // one ex2 snapshot
    typedef struct packed {
        logic                 valid;
        logic [`EX_XLEN-1:0]  pc0;
        logic [`EX_XLEN-1:0]  pc1;
        logic [`EX_XLEN-1:0]  inst0;
        logic [`EX_XLEN-1:0]  inst1;
        logic [`EX_REG_W-1:0] rd0;
        logic [`EX_REG_W-1:0] rd1;
        logic [`EX_XLEN-1:0]  data0;
        logic [`EX_XLEN-1:0]  data1;
        logic                 we0;
        logic                 we1;
        logic                 csr_ren;
        logic                 excp_flag;
        logic [6:0]           exception;
        logic [`EX_XLEN-1:0]  badv;
    } ex2_t;

    logic clk = 1'b0;
    logic rst_n;
    logic [`EX_XLEN-1:0] pc0, pc1, inst0, inst1;
    logic [`EX_XLEN-1:0] src_a0, src_b0, src_a1, src_b1, csr_rdata;
    logic ex1_readygo, ex2_allowin, flush;
    logic ex1_allowin, ex2_valid, ex2_we0, ex2_we1, ex2_csr_ren, ex2_excp_flag;
    logic [`EX_CSR_W-1:0] csr_addr;
    logic [`EX_XLEN-1:0] ex2_pc0, ex2_pc1, ex2_inst0, ex2_inst1;
    logic [`EX_XLEN-1:0] ex2_data0, ex2_data1, ex2_badv;
    logic [`EX_REG_W-1:0] ex2_rd0, ex2_rd1;
    excp_e ex2_exception;

    // model state
    logic [31:0] lfsr = 32'h1a4e;
    ex2_t        exp;
    logic        checks_on = 1'b0;
    int          div_edges = 0;
    int          accepted = 0;
    int          cycle_count = 0;

    always #10 clk = ~clk;

    ex_top dut0 (
        .clk(clk), .rst_n(rst_n), .pc0(pc0), .pc1(pc1), .inst0(inst0), .inst1(inst1),
        .src_a0(src_a0), .src_b0(src_b0), .src_a1(src_a1), .src_b1(src_b1),
        .csr_rdata(csr_rdata), .ex1_readygo(ex1_readygo), .ex2_allowin(ex2_allowin),
        .flush(flush), .ex1_allowin(ex1_allowin), .csr_addr(csr_addr),
        .ex2_valid(ex2_valid), .ex2_pc0(ex2_pc0), .ex2_pc1(ex2_pc1),
        .ex2_inst0(ex2_inst0), .ex2_inst1(ex2_inst1), .ex2_rd0(ex2_rd0), .ex2_rd1(ex2_rd1),
        .ex2_data0(ex2_data0), .ex2_data1(ex2_data1), .ex2_we0(ex2_we0), .ex2_we1(ex2_we1),
        .ex2_csr_ren(ex2_csr_ren), .ex2_excp_flag(ex2_excp_flag),
        .ex2_exception(ex2_exception), .ex2_badv(ex2_badv)
    );

    // taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // one lfsr step per bit handed out
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic logic is_divide(input logic [5:0] opc);
        return (opc == OP_DIVU) || (opc == OP_MODU);
    endfunction

    function automatic logic [31:0] alu_model(input logic [5:0] opc, input logic [31:0] a,
                                               input logic [31:0] b, input logic [31:0] imm);
        logic [31:0] r;
        case (opc)
            OP_ADD:  r = a + b;
            OP_SUB:  r = a - b;
            OP_AND:  r = a & b;
            OP_OR:   r = a | b;
            OP_XOR:  r = a ^ b;
            // shift by rk[4:0]
            OP_SLL:  r = a << b[4:0];
            OP_SRL:  r = a >> b[4:0];
            OP_SLTU: r = (a < b) ? 32'd1 : 32'd0;
            OP_ADDI: r = a + imm;
            default: r = '0;
        endcase
        return r;
    endfunction

    function automatic ex2_t bubble_value();
        ex2_t r;
        r = '0;
        r.inst0     = `EX_INST_NOP;
        r.inst1     = `EX_INST_NOP;
        r.exception = EXC_NONE;
        return r;
    endfunction

    // expected ex2 contents for an accepted pair
    function automatic ex2_t expect_pair(input logic [31:0] p0, input logic [31:0] p1,
                                         input logic [31:0] i0, input logic [31:0] i1,
                                         input logic [31:0] a0, input logic [31:0] b0,
                                         input logic [31:0] a1, input logic [31:0] b1,
                                         input logic [31:0] csr);
        ex2_t        r;
        logic [5:0]  opc0;
        logic [5:0]  opc1;
        logic [31:0] imm0;
        logic [31:0] imm1;
        logic        ill0;
        logic        ill1;
        logic        exc0;
        logic        exc1;
        opc0 = i0[31:26];
        opc1 = i1[31:26];
        imm0 = {{16{i0[15]}}, i0[15:0]};
        imm1 = {{16{i1[15]}}, i1[15:0]};
        ill0 = (opc0 > OP_SYSCALL);
        // divu, modu, csrrd and syscall are lane 0 only
        ill1 = (opc1 >= OP_DIVU);
        exc0 = ill0 || (opc0 == OP_SYSCALL);
        exc1 = ill1;
        r.valid = 1'b1;
        r.pc0   = p0;
        r.pc1   = p1;
        r.inst0 = i0;
        r.inst1 = i1;
        r.rd0   = i0[25:21];
        r.rd1   = i1[25:21];
        case (opc0)
            // divide by zero gives all ones and the dividend back
            OP_DIVU:  r.data0 = (b0 == 0) ? '1 : a0 / b0;
            OP_MODU:  r.data0 = (b0 == 0) ? a0 : a0 % b0;
            OP_CSRRD: r.data0 = csr;
            default:  r.data0 = alu_model(opc0, a0, b0, imm0);
        endcase
        r.data1     = alu_model(opc1, a1, b1, imm1);
        r.we0       = (r.rd0 != 0) && !exc0 && (opc0 != OP_NOP) && (opc0 != OP_SYSCALL);
        r.we1       = (r.rd1 != 0) && !exc1 && !exc0 && (opc1 != OP_NOP);
        r.csr_ren   = (opc0 == OP_CSRRD);
        r.excp_flag = exc0 || exc1;
        // older lane reports first
        if (exc0) begin
            r.exception = ill0 ? EXC_INE : EXC_SYS;
            r.badv      = p0;
        end else if (exc1) begin
            r.exception = EXC_INE;
            r.badv      = p1;
        end else begin
            r.exception = EXC_NONE;
            r.badv      = '0;
        end
        return r;
    endfunction

    // mostly legal codes, some lane-0-only ops and a few unknown ones
    function automatic logic [31:0] make_inst();
        logic [4:0]  pick;
        logic [5:0]  opc;
        logic [4:0]  rd;
        logic [31:0] rest;
        pick = 5'(rand_bits(5));
        if (pick < 5'd14) begin
            opc = {1'b0, pick};
        end else if (pick < 5'd30) begin
            opc = 6'd1 + {1'b0, pick % 5'd9};
        end else begin
            opc = 6'h0e + {1'b0, 5'(rand_bits(5))};
        end
        // r0 destination more often than uniform
        rd   = (rand_bits(3) == 0) ? 5'd0 : 5'(rand_bits(5));
        rest = rand_bits(21);
        return {opc, rd, rest[20:0]};
    endfunction

    // zero, small or full width
    function automatic logic [31:0] make_operand();
        logic [1:0]  mode;
        logic [31:0] v;
        mode = 2'(rand_bits(2));
        case (mode)
            2'd0:    v = '0;
            2'd1:    v = rand_bits(8);
            default: v = rand_bits(32);
        endcase
        return v;
    endfunction

    task automatic stop_on_failure();
        $display("TESTBENCH FAILED");
        $fatal(1, "run stopped at the first failure");
    endtask

    task automatic check_field(input string name, input logic [31:0] got,
                               input logic [31:0] want);
        assert (got === want) else begin
            $display("[ERROR] %s: got 0x%08h, expected 0x%08h", name, got, want);
            stop_on_failure();
        end
    endtask

    task automatic compare_outputs();
        check_field("ex2_valid", ex2_valid, exp.valid);
        check_field("ex2_pc0", ex2_pc0, exp.pc0);
        check_field("ex2_pc1", ex2_pc1, exp.pc1);
        check_field("ex2_inst0", ex2_inst0, exp.inst0);
        check_field("ex2_inst1", ex2_inst1, exp.inst1);
        check_field("ex2_rd0", ex2_rd0, exp.rd0);
        check_field("ex2_rd1", ex2_rd1, exp.rd1);
        check_field("ex2_data0", ex2_data0, exp.data0);
        check_field("ex2_data1", ex2_data1, exp.data1);
        check_field("ex2_we0", ex2_we0, exp.we0);
        check_field("ex2_we1", ex2_we1, exp.we1);
        check_field("ex2_csr_ren", ex2_csr_ren, exp.csr_ren);
        check_field("ex2_excp_flag", ex2_excp_flag, exp.excp_flag);
        check_field("ex2_exception", ex2_exception, exp.exception);
        check_field("ex2_badv", ex2_badv, exp.badv);
    endtask

    // compare first and then advance the model on pre-edge values
    always @(posedge clk) begin : monitor
        logic div0_now;
        logic allow_exp;
        logic fire;
        cycle_count++;
        assert (cycle_count < TIMEOUT_CYCLES) else begin
            $display("timeout after %0d cycles with %0d of %0d pairs accepted",
                     cycle_count, accepted, NUM_PAIRS);
            stop_on_failure();
        end
        if (checks_on) begin
            compare_outputs();
        end
        // divide holds ex1 for EX_DIV_CYCLES+1 edges after it shows up
        div0_now  = ex1_readygo && is_divide(inst0[31:26]);
        allow_exp = ex2_allowin && !(div0_now && (div_edges < `EX_DIV_CYCLES + 1));
        fire      = ex1_readygo && allow_exp;
        if (rst_n) begin
            check_field("ex1_allowin", ex1_allowin, allow_exp);
            check_field("csr_addr", csr_addr, inst0[`EX_CSR_W-1:0]);
        end
        if (!rst_n) begin
            exp       = bubble_value();
            div_edges = 0;
            checks_on = 1'b1;
        end else begin
            if (flush) begin
                exp = bubble_value();
            end else if (fire) begin
                exp = expect_pair(pc0, pc1, inst0, inst1, src_a0, src_b0,
                                  src_a1, src_b1, csr_rdata);
            end else if (!ex1_readygo && ex2_allowin) begin
                exp = bubble_value();
            end
            // a stalled ex2 keeps the expectation
            if (fire) begin
                div_edges = 0;
                accepted++;
            end else if (div0_now) begin
                div_edges++;
            end
        end
    end

    // back-pressure 1 in 4 and flush 1 in 16
    task automatic drive_control();
        ex2_allowin = (rand_bits(2) != 0);
        flush       = (rand_bits(4) == 0);
    endtask

    task automatic build_pair();
        pc0       = rand_bits(30) << 2;
        pc1       = pc0 + 32'd4;
        inst0     = make_inst();
        inst1     = make_inst();
        src_a0    = rand_bits(32);
        src_b0    = make_operand();
        src_a1    = rand_bits(32);
        src_b1    = make_operand();
        csr_rdata = rand_bits(32);
    endtask

    initial begin : stimulus
        logic fired;
        rst_n       = 1'b0;
        pc0         = '0;
        pc1         = '0;
        inst0       = `EX_INST_NOP;
        inst1       = `EX_INST_NOP;
        src_a0      = '0;
        src_b0      = '0;
        src_a1      = '0;
        src_b1      = '0;
        csr_rdata   = '0;
        ex1_readygo = 1'b0;
        ex2_allowin = 1'b1;
        flush       = 1'b0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        for (int p = 0; p < NUM_PAIRS; p++) begin
            // occasional empty ex1 cycles between pairs
            if (rand_bits(3) == 0) begin
                ex1_readygo = 1'b0;
                repeat (1 + rand_bits(2)) begin
                    drive_control();
                    @(negedge clk);
                end
            end
            build_pair();
            ex1_readygo = 1'b1;
            fired = 1'b0;
            // pair held until the edge that takes it
            while (!fired) begin
                drive_control();
                @(posedge clk);
                fired = ex1_allowin;
                @(negedge clk);
            end
        end
        ex1_readygo = 1'b0;
        ex2_allowin = 1'b1;
        flush       = 1'b0;
        repeat (4) @(negedge clk);
        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- project.f
+incdir+include
hdl/ex_uop_pkg.sv
hdl/ex_excp_pkg.sv
hdl/uop_decode.sv
hdl/alu_unit.sv
hdl/div_unit.sv
hdl/ex1_ex2_reg.sv
hdl/ex_top.sv
dv/ex_tb.sv

//--- Bender.yml
package:
  name: ex1_ex2_slice

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - hdl/ex_uop_pkg.sv
      - hdl/ex_excp_pkg.sv
      - hdl/uop_decode.sv
      - hdl/alu_unit.sv
      - hdl/div_unit.sv
      - hdl/ex1_ex2_reg.sv
      - hdl/ex_top.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - dv/ex_tb.sv
